// ==== design/clock_pkg.sv ====
package clock_pkg;

    localparam int TICKS_PER_SEC    = 200;         // clk_200 cycles per second
    localparam int HALF_SEC_TICKS   = 100;
    localparam int SCAN_CYCLES      = 4;           // Cycles per display digit
    localparam int BUZZ_HALF_PERIOD = 25;

    localparam int HOURS_MAX = 23;
    localparam int MINS_MAX  = 59;
    localparam int SECS_MAX  = 59;

    localparam int TICK_W = $clog2(TICKS_PER_SEC);
    localparam int SCAN_W = $clog2(SCAN_CYCLES);
    localparam int BUZZ_W = $clog2(BUZZ_HALF_PERIOD);

    // Bit positions inside a button command, lowest index wins
    localparam int BTN_CENTER = 0;
    localparam int BTN_RIGHT  = 1;
    localparam int BTN_LEFT   = 2;
    localparam int BTN_UP     = 3;
    localparam int BTN_DOWN   = 4;

    typedef logic [4:0] hour_t;
    typedef logic [5:0] min_t;
    typedef logic [5:0] sec_t;

    typedef enum logic [2:0] {
        CLOCK_RUN       = 3'b000,
        ALARM_RING      = 3'b001,
        SET_CLOCK_MINS  = 3'b010,
        SET_CLOCK_HOURS = 3'b011,
        SET_ALARM_MINS  = 3'b100,
        ADJUST_MENU     = 3'b110,
        SET_ALARM_HOURS = 3'b111
    } mode_t;

    typedef logic [4:0] btn_cmd_t;   // One-hot or zero
    typedef logic [6:0] seg_t;       // Active low, bit 0 is segment a
    typedef logic [3:0] anode_t;     // Active low, bit i is digit i

    // Hour field one up or down, wrapping within 0..HOURS_MAX
    function automatic hour_t step_hour(hour_t value, logic down);
        if (down) begin
            return (value == '0) ? hour_t'(HOURS_MAX) : value - 1'b1;
        end
        return (value == hour_t'(HOURS_MAX)) ? '0 : value + 1'b1;
    endfunction

    function automatic min_t step_min(min_t value, logic down);
        if (down) begin
            return (value == '0) ? min_t'(MINS_MAX) : value - 1'b1;
        end
        return (value == min_t'(MINS_MAX)) ? '0 : value + 1'b1;
    endfunction

endpackage

// ==== design/button_input.sv ====
`timescale 1ns/100ps

module button_input import clock_pkg::*; (
    input  logic     clk_200,
    input  logic     reset,
    input  logic     btn_center,
    input  logic     btn_right,
    input  logic     btn_left,
    input  logic     btn_up,
    input  logic     btn_down,
    output btn_cmd_t cmd
);

    btn_cmd_t btn_raw;
    btn_cmd_t sync_1;
    btn_cmd_t sync_2;
    btn_cmd_t sync_prev;
    btn_cmd_t rise;

    always_comb begin
        btn_raw             = '0;
        btn_raw[BTN_CENTER] = btn_center;
        btn_raw[BTN_RIGHT]  = btn_right;
        btn_raw[BTN_LEFT]   = btn_left;
        btn_raw[BTN_UP]     = btn_up;
        btn_raw[BTN_DOWN]   = btn_down;
    end

    assign rise = sync_2 & ~sync_prev;

    always_ff @(posedge clk_200 or posedge reset) begin
        if (reset) begin
            sync_1    <= '0;
            sync_2    <= '0;
            sync_prev <= '0;
            cmd       <= '0;
        end else begin
            sync_1    <= btn_raw;            // Metastability stages
            sync_2    <= sync_1;
            sync_prev <= sync_2;
            cmd       <= rise & (~rise + 1'b1);  // Keep lowest set bit only
        end
    end

    a_cmd_onehot: assert property (@(posedge clk_200) disable iff (reset) $onehot0(cmd));

endmodule

// ==== design/mode_control.sv ====
`timescale 1ns/100ps

module mode_control import clock_pkg::*; (
    input  logic       clk_200,
    input  logic       reset,
    input  btn_cmd_t   cmd,
    input  logic       alarm_hit,
    output logic       clock_hour_step,
    output logic       clock_min_step,
    output logic       alarm_hour_step,
    output logic       alarm_min_step,
    output logic       step_down,
    output logic       clock_run,
    output logic       ringing,
    output logic       show_alarm,
    output logic [5:0] led
);

    mode_t mode;
    mode_t mode_next;
    logic  adjusting;
    logic  step_req;

    always_comb begin
        mode_next = mode;
        case (mode)
            CLOCK_RUN: begin
                if (alarm_hit) begin
                    mode_next = ALARM_RING;
                end else if (cmd[BTN_CENTER]) begin
                    mode_next = ADJUST_MENU;
                end
            end
            ALARM_RING: begin
                if (cmd != '0) begin             // Any button silences
                    mode_next = CLOCK_RUN;
                end
            end
            default: begin
                if (cmd[BTN_CENTER]) begin
                    mode_next = CLOCK_RUN;
                end else if (cmd[BTN_RIGHT]) begin
                    case (mode)
                        SET_CLOCK_HOURS: mode_next = SET_CLOCK_MINS;
                        SET_CLOCK_MINS:  mode_next = SET_ALARM_HOURS;
                        SET_ALARM_HOURS: mode_next = SET_ALARM_MINS;
                        default:         mode_next = SET_CLOCK_HOURS;
                    endcase
                end else if (cmd[BTN_LEFT]) begin
                    case (mode)
                        SET_ALARM_MINS:  mode_next = SET_ALARM_HOURS;
                        SET_ALARM_HOURS: mode_next = SET_CLOCK_MINS;
                        SET_CLOCK_MINS:  mode_next = SET_CLOCK_HOURS;
                        default:         mode_next = SET_ALARM_MINS;
                    endcase
                end
            end
        endcase
    end

    always_ff @(posedge clk_200 or posedge reset) begin
        if (reset) begin
            mode <= CLOCK_RUN;
        end else begin
            mode <= mode_next;
        end
    end

    assign step_req  = cmd[BTN_UP] | cmd[BTN_DOWN];
    assign step_down = cmd[BTN_DOWN];

    assign clock_hour_step = step_req && (mode == SET_CLOCK_HOURS);
    assign clock_min_step  = step_req && (mode == SET_CLOCK_MINS);
    assign alarm_hour_step = step_req && (mode == SET_ALARM_HOURS);
    assign alarm_min_step  = step_req && (mode == SET_ALARM_MINS);

    assign clock_run  = (mode == CLOCK_RUN) || (mode == ALARM_RING);
    assign ringing    = (mode == ALARM_RING);
    assign show_alarm = (mode == SET_ALARM_HOURS) || (mode == SET_ALARM_MINS);
    assign adjusting  = !clock_run;              // Menu or any set state

    assign led[0] = adjusting;
    assign led[1] = (mode == SET_CLOCK_MINS);
    assign led[2] = (mode == SET_CLOCK_HOURS);
    assign led[3] = (mode == SET_ALARM_MINS);
    assign led[4] = (mode == SET_ALARM_HOURS);
    assign led[5] = ringing;

    // Step strobes are exclusive and never ride on a menu move
    a_one_strobe: assert property (@(posedge clk_200) disable iff (reset)
        $onehot0({clock_hour_step, clock_min_step, alarm_hour_step, alarm_min_step,
                  cmd[BTN_CENTER], cmd[BTN_RIGHT], cmd[BTN_LEFT]}));

endmodule

// ==== design/time_keeper.sv ====
`timescale 1ns/100ps

module time_keeper import clock_pkg::*; (
    input  logic  clk_200,
    input  logic  reset,
    input  logic  clock_run,
    input  logic  clock_hour_step,
    input  logic  clock_min_step,
    input  logic  step_down,
    output hour_t hours,
    output min_t  minutes,
    output sec_t  seconds,
    output logic  first_half
);

    logic [TICK_W-1:0] tick_cnt;
    logic              sec_end;

    assign sec_end    = clock_run && (tick_cnt == TICK_W'(TICKS_PER_SEC - 1));
    assign first_half = (tick_cnt < TICK_W'(HALF_SEC_TICKS));

    always_ff @(posedge clk_200 or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
            seconds  <= '0;
            minutes  <= '0;
            hours    <= '0;
        end else if (clock_hour_step || clock_min_step) begin
            // Manual set restarts the current minute
            tick_cnt <= '0;
            seconds  <= '0;
            if (clock_hour_step) begin
                hours <= step_hour(hours, step_down);
            end else begin
                minutes <= step_min(minutes, step_down);   // No carry into hours
            end
        end else if (clock_run) begin
            if (sec_end) begin
                tick_cnt <= '0;
                if (seconds == sec_t'(SECS_MAX)) begin
                    seconds <= '0;
                    minutes <= step_min(minutes, 1'b0);
                    if (minutes == min_t'(MINS_MAX)) begin
                        hours <= step_hour(hours, 1'b0);
                    end
                end else begin
                    seconds <= seconds + 1'b1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    a_time_range: assert property (@(posedge clk_200) disable iff (reset)
        hours <= hour_t'(HOURS_MAX) && minutes <= min_t'(MINS_MAX)
        && seconds <= sec_t'(SECS_MAX) && tick_cnt < TICK_W'(TICKS_PER_SEC));

endmodule

// ==== design/alarm_register.sv ====
`timescale 1ns/100ps

module alarm_register import clock_pkg::*; (
    input  logic  clk_200,
    input  logic  reset,
    input  logic  alarm_hour_step,
    input  logic  alarm_min_step,
    input  logic  step_down,
    output hour_t alarm_hours,
    output min_t  alarm_minutes
);

    always_ff @(posedge clk_200 or posedge reset) begin
        if (reset) begin
            alarm_hours   <= '0;
            alarm_minutes <= '0;
        end else begin
            if (alarm_hour_step) begin
                alarm_hours <= step_hour(alarm_hours, step_down);
            end
            if (alarm_min_step) begin
                alarm_minutes <= step_min(alarm_minutes, step_down);   // Wraps, no carry
            end
        end
    end

    a_alarm_range: assert property (@(posedge clk_200) disable iff (reset)
        alarm_hours <= hour_t'(HOURS_MAX) && alarm_minutes <= min_t'(MINS_MAX));

endmodule

// ==== design/alarm_sounder.sv ====
`timescale 1ns/100ps

module alarm_sounder import clock_pkg::*; (
    input  logic  clk_200,
    input  logic  reset,
    input  hour_t hours,
    input  min_t  minutes,
    input  sec_t  seconds,
    input  hour_t alarm_hours,
    input  min_t  alarm_minutes,
    input  logic  ringing,
    output logic  alarm_hit,
    output logic  buzzer
);

    logic              match;
    logic              match_q;
    logic [BUZZ_W-1:0] buzz_cnt;

    assign match     = (hours == alarm_hours) && (minutes == alarm_minutes) && (seconds == '0);
    assign alarm_hit = match && !match_q;

    always_ff @(posedge clk_200 or posedge reset) begin
        if (reset) begin
            match_q <= 1'b1;                     // No ring on 00:00 at power-up
        end else begin
            match_q <= match;
        end
    end

    always_ff @(posedge clk_200 or posedge reset) begin
        if (reset) begin
            buzz_cnt <= '0;
            buzzer   <= 1'b0;
        end else if (!ringing) begin
            buzz_cnt <= '0;
            buzzer   <= 1'b0;
        end else if (buzz_cnt == BUZZ_W'(BUZZ_HALF_PERIOD - 1)) begin
            buzz_cnt <= '0;
            buzzer   <= ~buzzer;                 // Tone edge
        end else begin
            buzz_cnt <= buzz_cnt + 1'b1;
        end
    end

endmodule

// ==== design/display_scan.sv ====
`timescale 1ns/100ps

module display_scan import clock_pkg::*; (
    input  logic   clk_200,
    input  logic   reset,
    input  logic   en,
    input  hour_t  hours,
    input  min_t   minutes,
    input  hour_t  alarm_hours,
    input  min_t   alarm_minutes,
    input  logic   show_alarm,
    input  logic   clock_run,
    input  logic   first_half,
    output seg_t   segments,
    output anode_t anode_active,
    output logic   dp
);

    logic [SCAN_W-1:0] scan_cnt;
    logic [1:0]        digit;                    // 0 is hours tens
    hour_t             hour_sel;
    min_t              min_sel;
    min_t              field;
    logic [3:0]        digit_val;

    function automatic seg_t decode(logic [3:0] value);
        case (value)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            default: return 7'b1111111;
        endcase
    endfunction

    always_comb begin
        hour_sel  = show_alarm ? alarm_hours : hours;
        min_sel   = show_alarm ? alarm_minutes : minutes;
        field     = digit[1] ? min_sel : {1'b0, hour_sel};
        digit_val = digit[0] ? 4'(field % 6'd10) : 4'(field / 6'd10);
    end

    always_ff @(posedge clk_200 or posedge reset) begin
        if (reset) begin
            scan_cnt     <= '0;
            digit        <= '0;
            anode_active <= 4'b1110;
            segments     <= '1;
            dp           <= 1'b1;
        end else begin
            if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1)) begin
                scan_cnt <= '0;
                digit    <= digit + 1'b1;
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
            anode_active <= en ? ~(anode_t'(1) << digit) : '1;   // Blank when disabled
            segments     <= decode(digit_val);
            dp           <= !((digit == 2'd1) && clock_run && first_half);
        end
    end

endmodule

// ==== design/digital_clock_top.sv ====
`timescale 1ns/100ps

module digital_clock_top import clock_pkg::*; (
    input  logic       clk_200,
    input  logic       reset,
    input  logic       en,
    input  logic       btn_center,
    input  logic       btn_right,
    input  logic       btn_left,
    input  logic       btn_up,
    input  logic       btn_down,
    output seg_t       segments,
    output logic       dp,
    output anode_t     anode_active,
    output logic [5:0] led,
    output logic       buzzer
);

    btn_cmd_t cmd;
    logic     clock_hour_step;
    logic     clock_min_step;
    logic     alarm_hour_step;
    logic     alarm_min_step;
    logic     step_down;
    logic     clock_run;
    logic     ringing;
    logic     show_alarm;
    logic     alarm_hit;
    logic     first_half;
    hour_t    hours;
    min_t     minutes;
    sec_t     seconds;
    hour_t    alarm_hours;
    min_t     alarm_minutes;

    button_input u_button_input (
        .clk_200    (clk_200),
        .reset      (reset),
        .btn_center (btn_center),
        .btn_right  (btn_right),
        .btn_left   (btn_left),
        .btn_up     (btn_up),
        .btn_down   (btn_down),
        .cmd        (cmd)
    );

    mode_control u_mode_control (
        .clk_200         (clk_200),
        .reset           (reset),
        .cmd             (cmd),
        .alarm_hit       (alarm_hit),
        .clock_hour_step (clock_hour_step),
        .clock_min_step  (clock_min_step),
        .alarm_hour_step (alarm_hour_step),
        .alarm_min_step  (alarm_min_step),
        .step_down       (step_down),
        .clock_run       (clock_run),
        .ringing         (ringing),
        .show_alarm      (show_alarm),
        .led             (led)
    );

    time_keeper u_time_keeper (
        .clk_200         (clk_200),
        .reset           (reset),
        .clock_run       (clock_run),
        .clock_hour_step (clock_hour_step),
        .clock_min_step  (clock_min_step),
        .step_down       (step_down),
        .hours           (hours),
        .minutes         (minutes),
        .seconds         (seconds),
        .first_half      (first_half)
    );

    alarm_register u_alarm_register (
        .clk_200         (clk_200),
        .reset           (reset),
        .alarm_hour_step (alarm_hour_step),
        .alarm_min_step  (alarm_min_step),
        .step_down       (step_down),
        .alarm_hours     (alarm_hours),
        .alarm_minutes   (alarm_minutes)
    );

    alarm_sounder u_alarm_sounder (
        .clk_200       (clk_200),
        .reset         (reset),
        .hours         (hours),
        .minutes       (minutes),
        .seconds       (seconds),
        .alarm_hours   (alarm_hours),
        .alarm_minutes (alarm_minutes),
        .ringing       (ringing),
        .alarm_hit     (alarm_hit),
        .buzzer        (buzzer)
    );

    display_scan u_display_scan (
        .clk_200       (clk_200),
        .reset         (reset),
        .en            (en),
        .hours         (hours),
        .minutes       (minutes),
        .alarm_hours   (alarm_hours),
        .alarm_minutes (alarm_minutes),
        .show_alarm    (show_alarm),
        .clock_run     (clock_run),
        .first_half    (first_half),
        .segments      (segments),
        .anode_active  (anode_active),
        .dp            (dp)
    );

endmodule

// ==== verif/tb_digital_clock.sv ====
`timescale 1ns/100ps

module tb_digital_clock import clock_pkg::*; ();

    localparam int MAX_CYCLES = 90000;          // Two simulated minutes plus headroom
    localparam logic [4:0] B_CENTER = 5'b00001;
    localparam logic [4:0] B_RIGHT  = 5'b00010;
    localparam logic [4:0] B_LEFT   = 5'b00100;
    localparam logic [4:0] B_UP     = 5'b01000;
    localparam logic [4:0] B_DOWN   = 5'b10000;

    logic       clk_200 = 1'b0;
    logic       reset = 1'b1;
    logic       en = 1'b1;
    logic [4:0] buttons = '0;
    seg_t       segments;
    logic       dp;
    anode_t     anode_active;
    logic [5:0] led;
    logic       buzzer;

    int cycle_cnt = 0;
    int run_start = 0;
    int resume_cycle = 0;
    int check_count = 0;
    int error_count = 0;
    int errors_before = 0;

    digital_clock_top uut (
        .clk_200      (clk_200),
        .reset        (reset),
        .en           (en),
        .btn_center   (buttons[0]),
        .btn_right    (buttons[1]),
        .btn_left     (buttons[2]),
        .btn_up       (buttons[3]),
        .btn_down     (buttons[4]),
        .segments     (segments),
        .dp           (dp),
        .anode_active (anode_active),
        .led          (led),
        .buzzer       (buzzer)
    );

    always #50 clk_200 = ~clk_200;

    always @(posedge clk_200) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    // Active-low segments, bit 0 is segment a
    function automatic int seg_to_digit(seg_t pattern);
        case (pattern)
            7'b1000000: return 0;
            7'b1111001: return 1;
            7'b0100100: return 2;
            7'b0110000: return 3;
            7'b0011001: return 4;
            7'b0010010: return 5;
            7'b0000010: return 6;
            7'b1111000: return 7;
            7'b0000000: return 8;
            7'b0010000: return 9;
            default:    return -1;
        endcase
    endfunction

    task automatic press_button(input logic [4:0] mask);
        @(posedge clk_200);
        buttons <= mask;
        repeat (4) @(posedge clk_200);
        buttons <= '0;
        repeat (8) @(posedge clk_200);
    endtask

    task automatic wait_until_cycle(input int target);
        while (cycle_cnt < target) begin
            @(negedge clk_200);
        end
    endtask

    task automatic read_display(output int hh, output int mm);
        int digits[4];
        int waited;
        for (int i = 0; i < 4; i++) begin
            waited = 0;
            @(negedge clk_200);
            while (anode_active !== ~(anode_t'(1) << i) && waited < 64) begin
                @(negedge clk_200);
                waited++;
            end
            if (waited >= 64) begin
                $display("Digit %0d was never selected on the display", i);
                error_count++;
            end
            digits[i] = seg_to_digit(segments);
            if (digits[i] < 0) begin
                $display("Segment pattern 0x%0h on digit %0d is not a digit", segments, i);
                error_count++;
            end
        end
        hh = digits[0] * 10 + digits[1];
        mm = digits[2] * 10 + digits[3];
    endtask

    task automatic expect_display(input int hh, input int mm);
        int got_h;
        int got_m;
        read_display(got_h, got_m);
        check("display hours", got_h, hh);
        check("display minutes", got_m, mm);
    endtask

    task automatic test_reset_state();
        check("led", led, 6'b000000);
        check("buzzer", buzzer, 1'b0);
        expect_display(0, 0);
        report_test("reset state");
    endtask

    task automatic test_timekeeping();
        int low_cnt;
        int high_cnt;
        int stray_cnt;
        low_cnt = 0;
        high_cnt = 0;
        stray_cnt = 0;
        wait_until_cycle(run_start + 60 * TICKS_PER_SEC - 40);
        expect_display(0, 0);
        wait_until_cycle(run_start + 60 * TICKS_PER_SEC + 40);
        expect_display(0, 1);
        // Edge of a second roll, dp trails first_half by one cycle
        wait_until_cycle(run_start + 61 * TICKS_PER_SEC + 1);
        for (int j = 0; j < TICKS_PER_SEC; j++) begin
            @(negedge clk_200);
            if (anode_active === 4'b1101 && j < HALF_SEC_TICKS) begin
                if (dp === 1'b0) begin
                    low_cnt++;
                end else begin
                    stray_cnt++;
                end
            end else if (anode_active === 4'b1101) begin
                if (dp === 1'b1) begin
                    high_cnt++;
                end else begin
                    stray_cnt++;
                end
            end else if (dp === 1'b0) begin
                stray_cnt++;
            end
        end
        check("dp low in first half", low_cnt >= 20 && low_cnt <= 30, 1);
        check("dp high in second half", high_cnt >= 20 && high_cnt <= 30, 1);
        check("dp wrong samples", stray_cnt, 0);
        report_test("timekeeping");
    endtask

    task automatic test_clock_adjust();
        press_button(B_CENTER);
        check("led", led, 6'b000001);
        press_button(B_RIGHT);
        check("led", led, 6'b000101);
        press_button(B_DOWN);
        expect_display(23, 1);                   // Hours wrap below zero
        press_button(B_UP);
        expect_display(0, 1);
        repeat (3) press_button(B_UP);
        check("led", led, 6'b000101);
        expect_display(3, 1);
        press_button(B_RIGHT);
        check("led", led, 6'b000011);
        press_button(B_DOWN);
        expect_display(3, 0);
        press_button(B_DOWN);
        expect_display(3, 59);
        press_button(B_DOWN);
        expect_display(3, 58);
        press_button(B_CENTER);
        check("led", led, 6'b000000);
        expect_display(3, 58);
        report_test("clock adjust");
    endtask

    task automatic test_alarm_set();
        press_button(B_CENTER);
        check("led", led, 6'b000001);
        press_button(B_LEFT);                    // Menu jumps back to alarm minutes
        check("led", led, 6'b001001);
        expect_display(0, 0);
        press_button(B_LEFT);
        check("led", led, 6'b010001);
        repeat (3) press_button(B_UP);
        expect_display(3, 0);
        press_button(B_RIGHT);
        check("led", led, 6'b001001);
        press_button(B_DOWN);
        expect_display(3, 59);
        press_button(B_CENTER);
        resume_cycle = cycle_cnt;
        check("led", led, 6'b000000);
        expect_display(3, 58);
        report_test("alarm set");
    endtask

    task automatic test_alarm_ring();
        int   waited;
        int   period;
        logic prev;
        waited = 0;
        while (led[5] !== 1'b1 && waited < 61 * TICKS_PER_SEC) begin
            @(negedge clk_200);
            waited++;
        end
        if (led[5] !== 1'b1) begin
            $display("Alarm did not ring within a minute of being armed");
            error_count++;
        end else begin
            check("alarm delay in range", cycle_cnt - resume_cycle >= 59 * TICKS_PER_SEC
                && cycle_cnt - resume_cycle <= 61 * TICKS_PER_SEC, 1);
            check("led", led, 6'b100000);
            expect_display(3, 59);
            prev = buzzer;
            waited = 0;
            while (buzzer === prev && waited < 4 * BUZZ_HALF_PERIOD) begin
                @(negedge clk_200);
                waited++;
            end
            if (buzzer === prev) begin
                $display("Buzzer did not toggle while the alarm was ringing");
                error_count++;
            end else begin
                prev = buzzer;
                period = 0;
                while (buzzer === prev && period < 4 * BUZZ_HALF_PERIOD) begin
                    @(negedge clk_200);
                    period++;
                end
                check("buzzer half period", period, BUZZ_HALF_PERIOD);
            end
        end
        // Cmd pulse comes 3 cycles after the press, then 4 cycles allowed
        @(posedge clk_200);
        buttons <= B_UP;
        waited = 0;
        while ((led[5] !== 1'b0 || buzzer !== 1'b0) && waited < 8) begin
            @(negedge clk_200);
            waited++;
        end
        check("led[5]", led[5], 1'b0);
        check("buzzer", buzzer, 1'b0);
        @(posedge clk_200);
        buttons <= '0;
        repeat (8) @(posedge clk_200);
        check("led", led, 6'b000000);
        expect_display(3, 59);
        report_test("alarm ring");
    endtask

    task automatic test_display_enable();
        int     bad_cnt;
        anode_t bad_val;
        bad_cnt = 0;
        bad_val = '1;
        @(posedge clk_200);
        en <= 1'b0;
        repeat (2) @(posedge clk_200);
        repeat (64) begin
            @(negedge clk_200);
            if (anode_active !== 4'b1111) begin
                bad_cnt++;
                bad_val = anode_active;
            end
        end
        check("anode_active while disabled", bad_val, 4'b1111);
        check("anode_active unblanked samples", bad_cnt, 0);
        @(posedge clk_200);
        en <= 1'b1;
        expect_display(3, 59);
        report_test("display enable");
    endtask

    initial begin
        repeat (3) @(posedge clk_200);
        reset <= 1'b0;
        run_start = cycle_cnt;
        repeat (2) @(posedge clk_200);
        test_reset_state();
        test_timekeeping();
        test_clock_adjust();
        test_alarm_set();
        test_alarm_ring();
        test_display_enable();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/clock_pkg.sv
design/button_input.sv
design/mode_control.sv
design/time_keeper.sv
design/alarm_register.sv
design/alarm_sounder.sv
design/display_scan.sv
design/digital_clock_top.sv
verif/tb_digital_clock.sv
